// File: tb/dataPathVectors.txt
// cmd_half_op_srcA_srcB_dst_value in hex; cmd 1 load, 2 op, 3 check, 4 incpc, 5 idle cycles
// regs 00-0F R0-R15, 10 PC, 11 IR, 12 RY, 13 MAR, 14 HI, 15 LO, 16 MDR, 17 RZLO, 18 RZHI
5_0_00_00_00_00_00000006
3_0_00_00_00_01_00000000
3_0_00_00_00_10_00000000
3_0_00_00_00_17_00000000
1_0_00_00_00_01_ABC00012
1_0_00_00_00_02_00000008
1_0_00_00_00_03_80000004
3_0_00_00_00_01_ABC00012
3_0_00_00_00_02_00000008
3_0_00_00_00_03_80000004
2_0_1A_01_02_04_C00012AB
2_0_08_01_02_05_12ABC000
2_0_07_01_02_04_C0001200
2_0_05_01_02_04_00ABC000
2_0_06_01_02_04_FFABC000
2_0_03_03_02_06_8000000C
2_0_04_03_02_06_7FFFFFFC
2_0_0A_01_03_06_80000000
2_0_0B_01_03_06_ABC00016
2_0_10_01_02_06_FFFFFFF8
2_0_11_02_01_06_543FFFED
2_0_0E_01_02_15_5E000090
2_1_0E_01_02_14_00000005
2_0_0F_01_02_07_15780002
2_1_0F_01_02_08_00000002
2_0_0F_01_00_07_FFFFFFFF
2_1_0F_01_00_08_ABC00012
1_0_00_00_00_10_00000100
4_0_00_00_00_00_00000000
4_0_00_00_00_00_00000000
3_0_00_00_00_10_00000102
1_0_00_00_00_11_12345678
3_0_00_00_00_11_12345678

// File: verilog.f
+incdir+hw
hw/busPkg.sv
hw/aluPkg.sv
hw/regCtrlIf.sv
hw/busMux.sv
hw/registerFile.sv
hw/dataRegisters.sv
hw/alu.sv
hw/dataPath.sv
tb/dataPathTb.sv

// File: Bender.yml
package:
  name: datapath

sources:
  - include_dirs:
      - hw
    files:
      - hw/busPkg.sv
      - hw/aluPkg.sv
      - hw/regCtrlIf.sv
      - hw/busMux.sv
      - hw/registerFile.sv
      - hw/dataRegisters.sv
      - hw/alu.sv
      - hw/dataPath.sv
  - target: test
    files:
      - tb/dataPathTb.sv

// File: tb/dataPathTb.sv
// testbench for dataPath, replays the command vectors in tb/dataPathVectors.txt and checks the bus
`timescale 1ns/10ps

module dataPathTb;
    import aluPkg::*;

    localparam int MaxVectors    = 64;
    localparam int FinishTimeout = 50;  // cycles allowed from start to finished

    logic        Clock, reset;
    logic        RFout, PCout, IRout, RYout, RZLOout, RZHIout, MARout, RHIout, RLOout, MDRout;
    logic        RFin, PCin, IRin, RYin, MARin, RHIin, RLOin, MDRin;
    logic        Read, IncPC, start, finished;
    logic [3:0]  RFSelect;
    logic [4:0]  opSelect;
    logic [31:0] Mdatain, BusMuxOut;

    logic [71:0] vectors [MaxVectors];
    logic [3:0]  cmd, half;
    logic [7:0]  op, srcA, srcB, dst;  // register codes, see the vector file header
    logic [31:0] value;
    int          waited;

    dataPath dut0 (.*);

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    task automatic idleControls;
        {RFout, PCout, IRout, RYout, RZLOout, RZHIout, MARout, RHIout, RLOout, MDRout} = '0;
        {RFin, PCin, IRin, RYin, MARin, RHIin, RLOin, MDRin} = '0;
        {Read, IncPC, start} = '0;
        RFSelect = '0;
        opSelect = '0;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected, actual);
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic reportProblem(input string what);
        $display("at %0t: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, what);
    endtask

    task automatic driveSource(input logic [7:0] code);
        if (code < 8'h10) begin
            RFout    = 1'b1;
            RFSelect = code[3:0];
        end else begin
            case (code)
                8'h10:   PCout   = 1'b1;
                8'h11:   IRout   = 1'b1;
                8'h12:   RYout   = 1'b1;
                8'h13:   MARout  = 1'b1;
                8'h14:   RHIout  = 1'b1;
                8'h15:   RLOout  = 1'b1;
                8'h16:   MDRout  = 1'b1;
                8'h17:   RZLOout = 1'b1;
                8'h18:   RZHIout = 1'b1;
                default: reportProblem("vector names an unknown bus source");
            endcase
        end
    endtask

    task automatic driveEnable(input logic [7:0] code);
        if (code < 8'h10) begin
            RFin     = 1'b1;
            RFSelect = code[3:0];
        end else begin
            case (code)
                8'h10:   PCin  = 1'b1;
                8'h11:   IRin  = 1'b1;
                8'h12:   RYin  = 1'b1;
                8'h13:   MARin = 1'b1;
                8'h14:   RHIin = 1'b1;
                8'h15:   RLOin = 1'b1;
                8'h16:   MDRin = 1'b1;
                default: reportProblem("vector names a register that cannot be loaded");
            endcase
        end
    endtask

    // bus is combinational, so it has settled shortly after the falling edge
    task automatic checkBus(input logic [31:0] expected);
        #2;
        assert (BusMuxOut === expected)
            else reportMismatch("BusMuxOut", expected, BusMuxOut);
    endtask

    // memory word into MDR, then MDR across the bus into the target
    task automatic loadRegister;
        idleControls;
        Mdatain = value;
        Read    = 1'b1;
        MDRin   = 1'b1;
        @(negedge Clock);
        idleControls;
        MDRout = 1'b1;
        driveEnable(dst);
        @(negedge Clock);
        idleControls;
    endtask

    task automatic checkRegister;
        idleControls;
        driveSource(dst);
        checkBus(value);
        @(negedge Clock);
        idleControls;
    endtask

    task automatic runOp;
        idleControls;
        driveSource(srcA);
        RYin = 1'b1;  // operand A sits in RY
        @(negedge Clock);
        idleControls;
        driveSource(srcB);
        opSelect = op[4:0];
        start    = 1'b1;
        @(negedge Clock);
        idleControls;
        waited = 1;
        while (finished !== 1'b1) begin
            if (waited >= FinishTimeout) reportProblem("timeout waiting for finished from the ALU");
            @(negedge Clock);
            waited++;
        end
        if (op[4:0] != opMul && op[4:0] != opDiv) begin
            assert (waited <= 2) else reportProblem("finished came late for a single-cycle op");
        end
        @(negedge Clock);  // RZ took the result on the finished edge
        driveSource(half[0] ? 8'h18 : 8'h17);
        driveEnable(dst);
        checkBus(value);
        @(negedge Clock);
        idleControls;
    endtask

    initial begin
        idleControls;
        Mdatain = '0;
        reset   = 1'b1;
        for (int i = 0; i < MaxVectors; i++) vectors[i] = '0;  // zero command ends the list
        $readmemh("tb/dataPathVectors.txt", vectors);
        repeat (16) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;
        assert (vectors[0][71:68] != 4'h0) else reportProblem("no command vectors were read");
        // every bus source reads zero straight out of reset
        for (int code = 0; code <= 'h18; code++) begin
            idleControls;
            driveSource(code[7:0]);
            checkBus('0);
            @(negedge Clock);
        end
        idleControls;
        for (int i = 0; i < MaxVectors && vectors[i][71:68] != 4'h0; i++) begin
            {cmd, half, op, srcA, srcB, dst, value} = vectors[i];
            case (cmd)
                4'h1: loadRegister;
                4'h2: runOp;
                4'h3: checkRegister;
                4'h4: begin
                    IncPC = 1'b1;
                    @(negedge Clock);
                    idleControls;
                end
                4'h5: begin
                    // no start yet, so finished must stay low
                    repeat (value) begin
                        assert (finished === 1'b0) else reportMismatch("finished", 0, finished);
                        @(negedge Clock);
                    end
                end
                default: reportProblem("unknown command in the vector file");
            endcase
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: hw/dataPath.sv
// single-bus datapath top level, plain strobes in and the bus value out for the testbench
`timescale 1ns/10ps
`include "datapath_cfg.svh"

module dataPath (
    input  logic                  Clock,
    input  logic                  reset,
    input  logic                  RFout, PCout, IRout, RYout, RZLOout, RZHIout,
    input  logic                  MARout, RHIout, RLOout, MDRout,
    input  logic                  RFin, PCin, IRin, RYin, MARin, RHIin, RLOin, MDRin,
    input  logic                  Read,
    input  logic                  IncPC,
    input  logic [3:0]            RFSelect,
    input  logic [4:0]            opSelect,
    input  logic                  start,
    input  logic [`DATA_WIDTH-1:0] Mdatain,
    output logic                  finished,
    output logic [`DATA_WIDTH-1:0] BusMuxOut
);
    import busPkg::*;
    import aluPkg::*;

    word_t  busValue;
    word_t  rfData, pcData, irData, ryData, rzLoData, rzHiData;
    word_t  marData, hiData, loData, mdrData;
    aluOp_t aluOp;
    logic [2*`DATA_WIDTH-1:0] aluResult;

    regCtrlIf ctrl (.Clock(Clock), .reset(reset));

    // bus sources
    assign ctrl.RFout   = RFout;
    assign ctrl.PCout   = PCout;
    assign ctrl.IRout   = IRout;
    assign ctrl.RYout   = RYout;
    assign ctrl.RZLOout = RZLOout;
    assign ctrl.RZHIout = RZHIout;
    assign ctrl.MARout  = MARout;
    assign ctrl.RHIout  = RHIout;
    assign ctrl.RLOout  = RLOout;
    assign ctrl.MDRout  = MDRout;
    // load enables
    assign ctrl.RFin  = RFin;
    assign ctrl.PCin  = PCin;
    assign ctrl.IRin  = IRin;
    assign ctrl.RYin  = RYin;
    assign ctrl.MARin = MARin;
    assign ctrl.RHIin = RHIin;
    assign ctrl.RLOin = RLOin;
    assign ctrl.MDRin = MDRin;
    assign ctrl.RFSelect = RFSelect;
    assign ctrl.Read     = Read;
    assign ctrl.IncPC    = IncPC;

    assign aluOp     = aluOp_t'(opSelect);  // unlisted codes fall to zero in the ALU
    assign BusMuxOut = busValue;

    busMux busMux0 (
        .ctrl(ctrl), .rfData(rfData), .pcData(pcData), .irData(irData), .ryData(ryData),
        .rzLoData(rzLoData), .rzHiData(rzHiData), .marData(marData), .hiData(hiData),
        .loData(loData), .mdrData(mdrData), .busValue(busValue)
    );

    registerFile registerFile0 (
        .Clock(Clock), .reset(reset), .ctrl(ctrl), .busValue(busValue), .rfData(rfData)
    );

    dataRegisters dataRegisters0 (
        .Clock(Clock), .reset(reset), .ctrl(ctrl), .busValue(busValue), .Mdatain(Mdatain),
        .aluResult(aluResult), .finished(finished), .pcData(pcData), .irData(irData),
        .ryData(ryData), .rzLoData(rzLoData), .rzHiData(rzHiData), .marData(marData),
        .hiData(hiData), .loData(loData), .mdrData(mdrData)
    );

    // operand A from RY, operand B straight off the bus in the start cycle
    alu alu0 (
        .Clock(Clock), .reset(reset), .start(start), .opSelect(aluOp),
        .operandA(ryData), .operandB(busValue), .result(aluResult), .finished(finished)
    );

endmodule

// File: hw/alu.sv
// multi-cycle ALU, one-cycle logic and shift ops plus 32-step mul/div, paced by start/finished
`timescale 1ns/10ps
`include "datapath_cfg.svh"

module alu (
    input  logic                     Clock,
    input  logic                     reset,
    input  logic                     start,
    input  aluPkg::aluOp_t           opSelect,
    input  busPkg::word_t            operandA,
    input  busPkg::word_t            operandB,
    output logic [2*`DATA_WIDTH-1:0] result,
    output logic                     finished
);
    import busPkg::*;
    import aluPkg::*;

    localparam int W  = `DATA_WIDTH;
    localparam int SW = $clog2(W);

    aluState_t      state;
    aluOp_t         opReg;
    word_t          aReg, bReg;
    logic [2*W-1:0] acc;         // {hi, lo} working pair for mul/div
    logic [SW-1:0]  stepCount;
    logic           startsLoop;
    logic           accepted;

    word_t          logicResult;
    logic [2*W-1:0] rolWide, rorWide;
    logic [SW-1:0]  rotAmt;
    logic [W:0]     mulSum;
    logic [W:0]     divPartial, divTrial;
    logic           divFits;
    logic           divByZero;

    assign startsLoop = (opSelect == opMul) || (opSelect == opDiv);
    assign accepted   = (state == idle) && start;  // start outside idle is dropped
    assign finished   = (state == done);

    // sequencing: one cycle in done for every op, W cycles in iterate before it for mul/div
    always_ff @(posedge Clock) begin
        if (reset) begin
            state     <= idle;
            stepCount <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state     <= startsLoop ? iterate : done;
                        stepCount <= '0;
                    end
                end
                iterate: begin
                    stepCount <= stepCount + 1'b1;
                    if (&stepCount) state <= done;  // last of the W steps
                end
                default: state <= idle;
            endcase
        end
    end

    // unsigned shift-add multiply step, multiplier shifts out of the low half
    assign mulSum = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, aReg} : '0);

    // restoring divide step, the bit shifted out of hi stays in divPartial
    assign divPartial = acc[2*W-1:W-1];
    assign divTrial   = divPartial - {1'b0, bReg};
    assign divFits    = ~divTrial[W];
    assign divByZero  = (bReg == '0);

    always_ff @(posedge Clock) begin
        if (accepted) begin
            opReg <= opSelect;
            aReg  <= operandA;
            bReg  <= operandB;
            // low half starts as the multiplier or the dividend
            acc   <= {{W{1'b0}}, (opSelect == opDiv) ? operandA : operandB};
        end else if (state == iterate) begin
            if (opReg == opMul) begin
                acc <= {mulSum, acc[W-1:1]};
            end else begin
                acc <= {divFits ? divTrial[W-1:0] : divPartial[W-1:0], acc[W-2:0], divFits};
            end
        end
    end

    assign rotAmt  = bReg[SW-1:0];
    assign rolWide = {aReg, aReg} << rotAmt;
    assign rorWide = {aReg, aReg} >> rotAmt;

    always_comb begin
        case (opReg)
            opAdd:   logicResult = aReg + bReg;
            opSub:   logicResult = aReg - bReg;
            opAnd:   logicResult = aReg & bReg;
            opOr:    logicResult = aReg | bReg;
            opShr:   logicResult = aReg >> bReg;
            opShra:  logicResult = $signed(aReg) >>> bReg;
            opShl:   logicResult = aReg << bReg;
            opRor:   logicResult = rorWide[W-1:0];
            opRol:   logicResult = rolWide[2*W-1:W];
            opNeg:   logicResult = -bReg;  // unary ops act on the bus operand
            opNot:   logicResult = ~bReg;
            default: logicResult = '0;
        endcase
    end

    // div: quotient low, remainder high; divide by zero gives all ones over the dividend
    always_comb begin
        case (opReg)
            opMul:   result = acc;
            opDiv:   result = divByZero ? {aReg, {W{1'b0}} - 1'b1} : acc;
            default: result = {{W{1'b0}}, logicResult};
        endcase
    end

    aluStartIdle: assert property (@(posedge Clock) disable iff (reset)
                                   start |-> state == idle)
        else $error("alu: start while busy, request ignored");

    // mul/div completion lands 33 cycles after the accepted start
    aluLoopLatency: assert property (@(posedge Clock) disable iff (reset)
                                     accepted && startsLoop |-> ##33 finished)
        else $error("alu: mul/div finished out of time");

endmodule

// File: hw/dataRegisters.sv
// special purpose registers on the bus: PC, IR, RY, RZ halves, MAR, HI, LO and MDR
`timescale 1ns/10ps
`include "datapath_cfg.svh"

module dataRegisters (
    input  logic                       Clock,
    input  logic                       reset,
    regCtrlIf.regs                     ctrl,
    input  busPkg::word_t              busValue,
    input  busPkg::word_t              Mdatain,
    input  logic [2*`DATA_WIDTH-1:0]   aluResult,
    input  logic                       finished,
    output busPkg::word_t              pcData,
    output busPkg::word_t              irData,
    output busPkg::word_t              ryData,
    output busPkg::word_t              rzLoData,
    output busPkg::word_t              rzHiData,
    output busPkg::word_t              marData,
    output busPkg::word_t              hiData,
    output busPkg::word_t              loData,
    output busPkg::word_t              mdrData
);
    import busPkg::*;

    word_t mdrNext;

    assign mdrNext = ctrl.Read ? Mdatain : busValue;  // memory read or bus write-back

    always_ff @(posedge Clock) begin
        if (reset) begin
            pcData   <= '0;
            irData   <= '0;
            ryData   <= '0;
            rzLoData <= '0;
            rzHiData <= '0;
            marData  <= '0;
            hiData   <= '0;
            loData   <= '0;
            mdrData  <= '0;
        end else begin
            if (ctrl.IncPC) begin
                pcData <= pcData + 1'b1;  // increment wins over a bus load
            end else if (ctrl.PCin) begin
                pcData <= busValue;
            end
            if (ctrl.IRin)  irData  <= busValue;
            if (ctrl.RYin)  ryData  <= busValue;  // ALU operand A
            if (ctrl.MARin) marData <= busValue;
            if (ctrl.RHIin) hiData  <= busValue;
            if (ctrl.RLOin) loData  <= busValue;
            if (ctrl.MDRin) mdrData <= mdrNext;
            // RZ has no strobe of its own, it follows the ALU completion pulse
            if (finished) begin
                rzLoData <= aluResult[`DATA_WIDTH-1:0];
                rzHiData <= aluResult[2*`DATA_WIDTH-1:`DATA_WIDTH];
            end
        end
    end

endmodule

// File: hw/registerFile.sv
// general purpose register file, written from the bus and read onto it through RFSelect
`timescale 1ns/10ps
`include "datapath_cfg.svh"

module registerFile (
    input  logic          Clock,
    input  logic          reset,
    regCtrlIf.regs        ctrl,
    input  busPkg::word_t busValue,
    output busPkg::word_t rfData
);
    import busPkg::*;

    word_t regs [`REG_COUNT];

    // whole file clears on reset so every register reads zero afterwards
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.RFin) begin
            regs[ctrl.RFSelect] <= busValue;
        end
    end

    // read port is combinational, same index as the write port
    assign rfData = regs[ctrl.RFSelect];

endmodule

// File: hw/busMux.sv
// common bus driver, an AND-OR selection of whichever source level is high
`timescale 1ns/10ps

module busMux (
    regCtrlIf.busSel      ctrl,
    input  busPkg::word_t rfData,
    input  busPkg::word_t pcData,
    input  busPkg::word_t irData,
    input  busPkg::word_t ryData,
    input  busPkg::word_t rzLoData,
    input  busPkg::word_t rzHiData,
    input  busPkg::word_t marData,
    input  busPkg::word_t hiData,
    input  busPkg::word_t loData,
    input  busPkg::word_t mdrData,
    output busPkg::word_t busValue
);
    import busPkg::*;

    localparam int W = $bits(word_t);

    logic [9:0] srcLevels;

    assign srcLevels = {ctrl.RFout, ctrl.PCout, ctrl.IRout, ctrl.RYout, ctrl.RZLOout,
                        ctrl.RZHIout, ctrl.MARout, ctrl.RHIout, ctrl.RLOout, ctrl.MDRout};

    // no source high leaves the bus at zero
    always_comb begin
        busValue = (rfData   & {W{ctrl.RFout}})
                 | (pcData   & {W{ctrl.PCout}})
                 | (irData   & {W{ctrl.IRout}})
                 | (ryData   & {W{ctrl.RYout}})
                 | (rzLoData & {W{ctrl.RZLOout}})
                 | (rzHiData & {W{ctrl.RZHIout}})
                 | (marData  & {W{ctrl.MARout}})
                 | (hiData   & {W{ctrl.RHIout}})
                 | (loData   & {W{ctrl.RLOout}})
                 | (mdrData  & {W{ctrl.MDRout}});
    end

    // two drivers at once would OR their words together on the bus
    busOneSource: assert property (@(posedge ctrl.Clock) disable iff (ctrl.reset)
                                   $onehot0(srcLevels))
        else $error("busMux: more than one bus source enabled (%b)", srcLevels);

endmodule

// File: hw/regCtrlIf.sv
// control strobes shared by the bus multiplexer and the register blocks inside the datapath
`timescale 1ns/10ps

interface regCtrlIf (
    input logic Clock,
    input logic reset
);
    import busPkg::*;

    // bus source levels, at most one high at a time
    logic RFout, PCout, IRout, RYout, RZLOout, RZHIout;
    logic MARout, RHIout, RLOout, MDRout;

    // register load enables, sampled on the rising Clock
    logic RFin, PCin, IRin, RYin, MARin, RHIin, RLOin, MDRin;

    regIndex_t RFSelect;
    logic      Read;   // MDR takes Mdatain instead of the bus
    logic      IncPC;

    // clock and reset only feed the one-source check in the mux
    modport busSel (
        input Clock, reset,
        input RFout, PCout, IRout, RYout, RZLOout, RZHIout,
        input MARout, RHIout, RLOout, MDRout
    );

    modport regs (
        input RFin, PCin, IRin, RYin, MARin, RHIin, RLOin, MDRin,
        input RFSelect, Read, IncPC
    );

endinterface

// File: hw/aluPkg.sv
// ALU opcode and sequencing types, imported by the ALU and the top level
package aluPkg;

    // opcode field values, matching the instruction encoding
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opShr  = 5'b00101,
        opShra = 5'b00110,
        opShl  = 5'b00111,
        opRor  = 5'b01000,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opMul  = 5'b01110,
        opDiv  = 5'b01111,
        opNeg  = 5'b10000,
        opNot  = 5'b10001,
        opRol  = 5'b11010
    } aluOp_t;

    // idle waits for start, iterate runs mul/div, done raises finished
    typedef enum logic [1:0] {
        idle    = 2'b00,
        iterate = 2'b01,
        done    = 2'b10
    } aluState_t;

endpackage

// File: hw/busPkg.sv
// bus-side types shared by the register blocks, the bus multiplexer and the top level
`include "datapath_cfg.svh"

package busPkg;

    // one word as it travels on the common bus
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // register file index, wide enough for REG_COUNT entries
    typedef logic [$clog2(`REG_COUNT)-1:0] regIndex_t;

endpackage

// File: hw/datapath_cfg.svh
// sizing macros for the datapath, included by the packages and by RTL that sizes data
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// width of the common bus and of every register on it
`define DATA_WIDTH 32

// number of general purpose registers in the register file
`define REG_COUNT 16

`endif
